// ==== hw/valu_pkg.sv ====
package valu_pkg;

	// Byte lane geometry
	localparam int LANE_W = 8;
	localparam int NUM_LANES = 8;
	// Full operand width, two APB words
	localparam int VEC_W = LANE_W * NUM_LANES;

	// APB bus widths
	localparam int APB_AW = 8;
	localparam int APB_DW = 32;

	// Opcodes keep the original R-type numbering
	typedef enum logic [4:0] {
		VNOP  = 5'd0,
		VAND  = 5'd1,
		VOR   = 5'd2,
		VXOR  = 5'd3,
		VNOT  = 5'd4,
		VMOV  = 5'd5,
		VADD  = 5'd6,
		VSUB  = 5'd7,
		VRTTH = 5'd13
	} valu_op_e;

	// Element width select
	typedef enum logic [1:0] {
		W8  = 2'd0,
		W16 = 2'd1,
		W32 = 2'd2,
		W64 = 2'd3
	} elem_width_e;

	// One issued command, valid for a single cycle
	typedef struct packed {
		logic valid;
		valu_op_e op;
		elem_width_e width;
		logic [VEC_W-1:0] a;
		logic [VEC_W-1:0] b;
	} alu_cmd_t;

	// Register map
	localparam logic [APB_AW-1:0] REG_A_LO = 8'h00;
	localparam logic [APB_AW-1:0] REG_A_HI = 8'h04;
	localparam logic [APB_AW-1:0] REG_B_LO = 8'h08;
	localparam logic [APB_AW-1:0] REG_B_HI = 8'h0C;
	localparam logic [APB_AW-1:0] REG_CTRL = 8'h10;
	localparam logic [APB_AW-1:0] REG_RES_LO = 8'h14;
	localparam logic [APB_AW-1:0] REG_RES_HI = 8'h18;

	// CTRL field positions
	// Op in bits 4..0
	localparam int CTRL_OP_LSB = 0;
	// Width in bits 9..8
	localparam int CTRL_WIDTH_LSB = 8;

endpackage

// ==== hw/valu_apb_regs.sv ====
`timescale 1ns/1ps

module valu_apb_regs (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [valu_pkg::APB_AW-1:0] paddr,
	input  logic [valu_pkg::APB_DW-1:0] pwdata,
	output logic [valu_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic [valu_pkg::VEC_W-1:0] result,
	output valu_pkg::alu_cmd_t cmd
);

	// Operand registers
	logic [valu_pkg::VEC_W-1:0] a_q;
	logic [valu_pkg::VEC_W-1:0] b_q;
	// Control fields
	valu_pkg::valu_op_e op_q;
	valu_pkg::elem_width_e width_q;
	// One-cycle issue strobe
	logic valid_q;

	// APB phase decode
	logic access;
	logic wr_en;
	logic rd_en;
	logic addr_hit;
	logic [valu_pkg::APB_DW-1:0] rd_data;

	assign access = psel & penable;
	assign wr_en = access & pwrite;
	assign rd_en = access & ~pwrite;

	// No wait states
	assign pready = 1'b1;

	// Address decode and readback mux
	always_comb begin
		addr_hit = 1'b1;
		rd_data = '0;
		case (paddr)
			valu_pkg::REG_A_LO: rd_data = a_q[31:0];
			valu_pkg::REG_A_HI: rd_data = a_q[63:32];
			valu_pkg::REG_B_LO: rd_data = b_q[31:0];
			valu_pkg::REG_B_HI: rd_data = b_q[63:32];
			valu_pkg::REG_CTRL: begin
				rd_data[valu_pkg::CTRL_OP_LSB +: 5] = op_q;
				rd_data[valu_pkg::CTRL_WIDTH_LSB +: 2] = width_q;
			end
			valu_pkg::REG_RES_LO: rd_data = result[31:0];
			valu_pkg::REG_RES_HI: rd_data = result[63:32];
			default: addr_hit = 1'b0;
		endcase
	end

	// Read data only in the access cycle
	assign prdata = rd_en ? rd_data : '0;
	// Unmapped address error, reads and writes alike
	assign pslverr = access & ~addr_hit;

	// Register writes
	// Result words are read only, writes dropped silently
	always_ff @(posedge clk) begin
		if (reset) begin
			a_q <= '0;
			b_q <= '0;
			op_q <= valu_pkg::VNOP;
			width_q <= valu_pkg::W8;
			valid_q <= 1'b0;
		end else begin
			// Strobe lasts one cycle
			valid_q <= 1'b0;
			if (wr_en) begin
				case (paddr)
					valu_pkg::REG_A_LO: a_q[31:0] <= pwdata;
					valu_pkg::REG_A_HI: a_q[63:32] <= pwdata;
					valu_pkg::REG_B_LO: b_q[31:0] <= pwdata;
					valu_pkg::REG_B_HI: b_q[63:32] <= pwdata;
					valu_pkg::REG_CTRL: begin
						op_q <= valu_pkg::valu_op_e'(pwdata[valu_pkg::CTRL_OP_LSB +: 5]);
						width_q <= valu_pkg::elem_width_e'(pwdata[valu_pkg::CTRL_WIDTH_LSB +: 2]);
						// Issue on every CTRL write
						valid_q <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// Command out of registers, stable while valid
	assign cmd = '{
		valid: valid_q,
		op: op_q,
		width: width_q,
		a: a_q,
		b: b_q
	};

	// Master protocol check
	a_penable_needs_psel: assert property (
		@(posedge clk) disable iff (reset) penable |-> psel
	);

	// Setup phase between transfers keeps issues apart
	a_valid_single: assert property (
		@(posedge clk) disable iff (reset) cmd.valid |=> !cmd.valid
	);

endmodule

// ==== hw/valu_lane.sv ====
`timescale 1ns/1ps

module valu_lane #(
	parameter int LANE_IDX = 0
) (
	input  valu_pkg::alu_cmd_t cmd,
	input  logic carry_in,
	output logic carry_out,
	output logic [valu_pkg::LANE_W-1:0] lane_res
);

	// This lane's operand bytes
	logic [valu_pkg::LANE_W-1:0] a_byte;
	logic [valu_pkg::LANE_W-1:0] b_byte;
	// Adder operand inverted for subtract
	logic [valu_pkg::LANE_W-1:0] b_add;
	logic is_sub;
	// Lowest byte of an element
	logic elem_start;
	logic cin;
	// Extra bit holds the carry
	logic [valu_pkg::LANE_W:0] sum;

	assign a_byte = cmd.a[LANE_IDX*valu_pkg::LANE_W +: valu_pkg::LANE_W];
	assign b_byte = cmd.b[LANE_IDX*valu_pkg::LANE_W +: valu_pkg::LANE_W];

	// Element boundary from lane position and width
	always_comb begin
		case (cmd.width)
			valu_pkg::W8: elem_start = 1'b1;
			valu_pkg::W16: elem_start = (LANE_IDX % 2) == 0;
			valu_pkg::W32: elem_start = (LANE_IDX % 4) == 0;
			default: elem_start = LANE_IDX == 0;
		endcase
	end

	assign is_sub = cmd.op == valu_pkg::VSUB;
	// a - b as a + ~b + 1
	assign b_add = is_sub ? ~b_byte : b_byte;
	// Chain cut at element start
	assign cin = elem_start ? is_sub : carry_in;
	assign sum = {1'b0, a_byte} + {1'b0, b_add} + {{valu_pkg::LANE_W{1'b0}}, cin};
	assign carry_out = sum[valu_pkg::LANE_W];

	// Per-lane op select
	// Half-swap is built in the result stage
	always_comb begin
		case (cmd.op)
			valu_pkg::VAND: lane_res = a_byte & b_byte;
			valu_pkg::VOR: lane_res = a_byte | b_byte;
			valu_pkg::VXOR: lane_res = a_byte ^ b_byte;
			valu_pkg::VNOT: lane_res = ~a_byte;
			valu_pkg::VMOV: lane_res = a_byte;
			valu_pkg::VADD, valu_pkg::VSUB: lane_res = sum[valu_pkg::LANE_W-1:0];
			default: lane_res = '0;
		endcase
	end

endmodule

// ==== hw/valu_result.sv ====
`timescale 1ns/1ps

module valu_result (
	input  logic clk,
	input  logic reset,
	input  valu_pkg::alu_cmd_t cmd,
	input  logic [valu_pkg::NUM_LANES-1:0][valu_pkg::LANE_W-1:0] lane_res,
	output logic [valu_pkg::VEC_W-1:0] result
);

	// Half-swap of each element of a
	logic [valu_pkg::VEC_W-1:0] swap;
	// Value loaded on valid
	logic [valu_pkg::VEC_W-1:0] next_res;

	always_comb begin
		swap = '0;
		case (cmd.width)
			valu_pkg::W8: begin
				// Nibbles
				for (int i = 0; i < 8; i++) begin
					swap[i*8 +: 8] = {cmd.a[i*8 +: 4], cmd.a[i*8+4 +: 4]};
				end
			end
			valu_pkg::W16: begin
				// Bytes
				for (int i = 0; i < 4; i++) begin
					swap[i*16 +: 16] = {cmd.a[i*16 +: 8], cmd.a[i*16+8 +: 8]};
				end
			end
			valu_pkg::W32: begin
				// 16-bit halves
				for (int i = 0; i < 2; i++) begin
					swap[i*32 +: 32] = {cmd.a[i*32 +: 16], cmd.a[i*32+16 +: 16]};
				end
			end
			default: begin
				// Words
				swap = {cmd.a[31:0], cmd.a[63:32]};
			end
		endcase
	end

	// Lanes in order, lane 0 at the low byte
	always_comb begin
		case (cmd.op)
			valu_pkg::VNOP,
			valu_pkg::VAND,
			valu_pkg::VOR,
			valu_pkg::VXOR,
			valu_pkg::VNOT,
			valu_pkg::VMOV,
			valu_pkg::VADD,
			valu_pkg::VSUB: next_res = lane_res;
			valu_pkg::VRTTH: next_res = swap;
			// Dropped opcodes read back zero
			default: next_res = '0;
		endcase
	end

	// Holds until the next issue
	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else if (cmd.valid) begin
			result <= next_res;
		end
	end

	// Only an issued command moves the result
	a_result_after_valid: assert property (
		@(posedge clk) disable iff (reset) $changed(result) |-> $past(cmd.valid)
	);

endmodule

// ==== hw/valu_top.sv ====
`timescale 1ns/1ps

module valu_top (
	input  logic clk,
	input  logic reset,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [valu_pkg::APB_AW-1:0] paddr,
	input  logic [valu_pkg::APB_DW-1:0] pwdata,
	output logic [valu_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	// Issued command to lanes and result stage
	valu_pkg::alu_cmd_t cmd;
	// Carry chain, entry k feeds lane k
	logic [valu_pkg::NUM_LANES:0] carry;
	// Raw lane outputs
	logic [valu_pkg::NUM_LANES-1:0][valu_pkg::LANE_W-1:0] lane_res;
	// Registered vector result
	logic [valu_pkg::VEC_W-1:0] result;

	// Register file and command issue
	valu_apb_regs valu_apb_regs_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.result(result),
		.cmd(cmd)
	);

	// Lowest lane starts the chain empty
	assign carry[0] = 1'b0;

	// Byte lanes
	for (genvar i = 0; i < valu_pkg::NUM_LANES; i++) begin : g_lane
		valu_lane #(
			.LANE_IDX(i)
		) valu_lane_i (
			.cmd(cmd),
			.carry_in(carry[i]),
			.carry_out(carry[i+1]),
			.lane_res(lane_res[i])
		);
	end

	// Merge, half-swap and result register
	valu_result valu_result_i (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.lane_res(lane_res),
		.result(result)
	);

endmodule

// ==== sim/valu_tb_table.svh ====
// Shared operands for the directed cases
localparam logic [63:0] OPND_A = 64'h0123_4567_89ab_cdef;
localparam logic [63:0] OPND_B = 64'hff00_f0f0_0f0f_00ff;
localparam logic [63:0] ONES = 64'hffff_ffff_ffff_ffff;

localparam int NUM_VEC = 27;

// Columns are op, width, a, b, expected
vec_t vec_table [NUM_VEC] = '{
	// Bitwise, width has no effect
	'{valu_pkg::VAND, valu_pkg::W8, OPND_A, OPND_B, 64'h0100_4060_090b_00ef},
	'{valu_pkg::VAND, valu_pkg::W64, OPND_A, OPND_B, 64'h0100_4060_090b_00ef},
	'{valu_pkg::VOR, valu_pkg::W16, OPND_A, OPND_B, 64'hff23_f5f7_8faf_cdff},
	'{valu_pkg::VXOR, valu_pkg::W32, OPND_A, OPND_B, 64'hfe23_b597_86a4_cd10},
	'{valu_pkg::VNOT, valu_pkg::W64, OPND_A, OPND_B, 64'hfedc_ba98_7654_3210},
	'{valu_pkg::VNOT, valu_pkg::W8, OPND_A, OPND_B, 64'hfedc_ba98_7654_3210},
	'{valu_pkg::VMOV, valu_pkg::W8, OPND_A, OPND_B, OPND_A},
	'{valu_pkg::VNOP, valu_pkg::W32, OPND_A, OPND_B, 64'h0},
	// Add with wraparound inside each element
	'{valu_pkg::VADD, valu_pkg::W8, OPND_A, OPND_B, 64'h0023_3557_98ba_cdee},
	'{valu_pkg::VADD, valu_pkg::W16, OPND_A, OPND_B, 64'h0023_3657_98ba_ceee},
	'{valu_pkg::VADD, valu_pkg::W32, OPND_A, OPND_B, 64'h0024_3657_98ba_ceee},
	// All ones plus one per element
	'{valu_pkg::VADD, valu_pkg::W8, ONES, 64'h0101_0101_0101_0101, 64'h0},
	'{valu_pkg::VADD, valu_pkg::W16, ONES, 64'h0001_0001_0001_0001, 64'h0},
	'{valu_pkg::VADD, valu_pkg::W32, ONES, 64'h0000_0001_0000_0001, 64'h0},
	'{valu_pkg::VADD, valu_pkg::W64, ONES, 64'h1, 64'h0},
	'{valu_pkg::VADD, valu_pkg::W8, 64'h0000_0000_0000_00ff, 64'h1, 64'h0},
	'{valu_pkg::VADD, valu_pkg::W64, 64'h0000_0000_ffff_ffff, 64'h1, 64'h0000_0001_0000_0000},
	// Subtract, borrow stays in the element
	'{valu_pkg::VSUB, valu_pkg::W8, OPND_A, OPND_B, 64'h0223_5577_7a9c_cdf0},
	'{valu_pkg::VSUB, valu_pkg::W16, OPND_A, OPND_B, 64'h0223_5477_7a9c_ccf0},
	'{valu_pkg::VSUB, valu_pkg::W8, 64'h0, 64'h0101_0101_0101_0101, ONES},
	'{valu_pkg::VSUB, valu_pkg::W16, 64'h0, 64'h0001_0001_0001_0001, ONES},
	'{valu_pkg::VSUB, valu_pkg::W32, 64'h0, 64'h0000_0001_0000_0001, ONES},
	'{valu_pkg::VSUB, valu_pkg::W64, 64'h0000_0001_0000_0000, 64'h1, 64'h0000_0000_ffff_ffff},
	// Half-swap of a
	'{valu_pkg::VRTTH, valu_pkg::W8, OPND_A, OPND_B, 64'h1032_5476_98ba_dcfe},
	'{valu_pkg::VRTTH, valu_pkg::W16, OPND_A, OPND_B, 64'h2301_6745_ab89_efcd},
	'{valu_pkg::VRTTH, valu_pkg::W32, OPND_A, OPND_B, 64'h4567_0123_cdef_89ab},
	'{valu_pkg::VRTTH, valu_pkg::W64, OPND_A, OPND_B, 64'h89ab_cdef_0123_4567}
};

// ==== sim/valu_tb.sv ====
`timescale 1ns/1ps

module valu_tb;

	// Directed table entry
	typedef struct packed {
		valu_pkg::valu_op_e op;
		valu_pkg::elem_width_e width;
		logic [valu_pkg::VEC_W-1:0] a;
		logic [valu_pkg::VEC_W-1:0] b;
		logic [valu_pkg::VEC_W-1:0] expected;
	} vec_t;

	`include "valu_tb_table.svh"

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	logic [valu_pkg::APB_AW-1:0] paddr;
	logic [valu_pkg::APB_DW-1:0] pwdata;
	logic [valu_pkg::APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;

	// Check and test tallies
	int err_count;
	int pass_count;
	int fail_count;
	int test_num;

	// Draw pools for random commands
	valu_pkg::valu_op_e ops [9] = '{valu_pkg::VNOP, valu_pkg::VAND, valu_pkg::VOR,
		valu_pkg::VXOR, valu_pkg::VNOT, valu_pkg::VMOV, valu_pkg::VADD, valu_pkg::VSUB,
		valu_pkg::VRTTH};
	valu_pkg::elem_width_e widths [4] = '{valu_pkg::W8, valu_pkg::W16, valu_pkg::W32,
		valu_pkg::W64};
	// Every mapped register
	logic [valu_pkg::APB_AW-1:0] map_addr [7] = '{valu_pkg::REG_A_LO, valu_pkg::REG_A_HI,
		valu_pkg::REG_B_LO, valu_pkg::REG_B_HI, valu_pkg::REG_CTRL, valu_pkg::REG_RES_LO,
		valu_pkg::REG_RES_HI};

	valu_top valu_top_i (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	// 100 ns clock
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
			err_count++;
		end
	endtask

	// One APB transfer, entered and left 2 ns after a rising edge
	task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic err);
		int waited;
		// Setup phase
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		waited = 0;
		// Sample mid cycle
		@(negedge clk);
		while (!pready && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (!pready) begin
			$display("APB transfer timed out at address 0x%h", addr);
			$display("sim failed");
			$finish;
		end else begin
			rdata = prdata;
			err = pslverr;
			// Transfer completes on this edge
			@(posedge clk);
			#2;
			psel = 1'b0;
			penable = 1'b0;
			pwrite = 1'b0;
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
		logic [31:0] unused_rdata;
		apb_xfer(1'b1, addr, data, unused_rdata, err);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
		apb_xfer(1'b0, addr, 32'h0, data, err);
	endtask

	// Read one register, expect data and no error
	task automatic read_check(input logic [7:0] addr, input string name,
			input logic [31:0] expected);
		logic [31:0] rdata;
		logic err;
		apb_read(addr, rdata, err);
		check_value(name, 64'(rdata), 64'(expected));
		check_value({"pslverr on ", name}, 64'(err), 64'h0);
	endtask

	// Load operands, issue, then read the result straight away
	task automatic run_cmd(input valu_pkg::valu_op_e op, input valu_pkg::elem_width_e width,
			input logic [63:0] a, input logic [63:0] b, output logic [63:0] res);
		logic [31:0] lo;
		logic [31:0] hi;
		logic err;
		apb_write(valu_pkg::REG_A_LO, a[31:0], err);
		apb_write(valu_pkg::REG_A_HI, a[63:32], err);
		apb_write(valu_pkg::REG_B_LO, b[31:0], err);
		apb_write(valu_pkg::REG_B_HI, b[63:32], err);
		apb_write(valu_pkg::REG_CTRL, {22'b0, width, 3'b0, op}, err);
		apb_read(valu_pkg::REG_RES_LO, lo, err);
		apb_read(valu_pkg::REG_RES_HI, hi, err);
		res = {hi, lo};
	endtask

	// Expected result, one element at a time
	function automatic logic [63:0] ref_result(input valu_pkg::valu_op_e op,
			input valu_pkg::elem_width_e width, input logic [63:0] a, input logic [63:0] b);
		int ew;
		int n;
		logic [63:0] mask;
		logic [63:0] ea;
		logic [63:0] eb;
		logic [63:0] er;
		logic [63:0] res;
		ew = 8 << int'(width);
		n = 64 / ew;
		mask = (ew == 64) ? '1 : ((64'd1 << ew) - 64'd1);
		res = '0;
		for (int e = 0; e < n; e++) begin
			ea = (a >> (e * ew)) & mask;
			eb = (b >> (e * ew)) & mask;
			case (op)
				valu_pkg::VAND: er = ea & eb;
				valu_pkg::VOR: er = ea | eb;
				valu_pkg::VXOR: er = ea ^ eb;
				valu_pkg::VNOT: er = ~ea;
				valu_pkg::VMOV: er = ea;
				valu_pkg::VADD: er = ea + eb;
				valu_pkg::VSUB: er = ea - eb;
				valu_pkg::VRTTH: er = (ea >> (ew / 2)) | (ea << (ew / 2));
				default: er = '0;
			endcase
			// Mask drops the carry out of the element
			res = res | ((er & mask) << (e * ew));
		end
		return res;
	endfunction

	task automatic end_test(input string name, input int errs_before);
		test_num++;
		if (err_count == errs_before) begin
			pass_count++;
			$display("test %0d %s: pass", test_num, name);
		end else begin
			fail_count++;
			$display("test %0d %s: FAIL", test_num, name);
		end
	endtask

	initial begin
		int unsigned seed_init;
		int errs_before;
		logic [31:0] rdata;
		logic err;
		logic [63:0] res;
		logic [63:0] a;
		logic [63:0] b;
		valu_pkg::valu_op_e op;
		valu_pkg::elem_width_e width;
		reset = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		test_num = 0;
		seed_init = $urandom(32'hbd7d);
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;

		// Everything clears on reset
		errs_before = err_count;
		foreach (map_addr[i]) begin
			read_check(map_addr[i], $sformatf("prdata at 0x%h", map_addr[i]), 32'h0);
		end
		end_test("reset values", errs_before);

		// Directed table
		for (int i = 0; i < NUM_VEC; i++) begin
			errs_before = err_count;
			run_cmd(vec_table[i].op, vec_table[i].width, vec_table[i].a, vec_table[i].b, res);
			check_value("result", res, vec_table[i].expected);
			end_test($sformatf("%s %s", vec_table[i].op.name(), vec_table[i].width.name()),
				errs_before);
		end

		// Register map behavior
		errs_before = err_count;
		run_cmd(valu_pkg::VMOV, valu_pkg::W64, 64'h1234_5678_dead_beef,
			64'h8796_a5b4_0f1e_2d3c, res);
		read_check(valu_pkg::REG_A_LO, "A_LO", 32'hdead_beef);
		read_check(valu_pkg::REG_A_HI, "A_HI", 32'h1234_5678);
		read_check(valu_pkg::REG_B_LO, "B_LO", 32'h0f1e_2d3c);
		read_check(valu_pkg::REG_B_HI, "B_HI", 32'h8796_a5b4);
		read_check(valu_pkg::REG_CTRL, "CTRL", {22'b0, valu_pkg::W64, 3'b0, valu_pkg::VMOV});
		// Result words are read only
		apb_write(valu_pkg::REG_RES_LO, 32'h5555_aaaa, err);
		check_value("pslverr on RES_LO write", 64'(err), 64'h0);
		apb_write(valu_pkg::REG_RES_HI, 32'haaaa_5555, err);
		check_value("pslverr on RES_HI write", 64'(err), 64'h0);
		read_check(valu_pkg::REG_RES_LO, "RES_LO", 32'hdead_beef);
		read_check(valu_pkg::REG_RES_HI, "RES_HI", 32'h1234_5678);
		// Holes in the map
		apb_read(8'h1c, rdata, err);
		check_value("pslverr on read 0x1c", 64'(err), 64'h1);
		apb_write(8'h40, 32'h1, err);
		check_value("pslverr on write 0x40", 64'(err), 64'h1);
		apb_read(8'h02, rdata, err);
		check_value("pslverr on read 0x02", 64'(err), 64'h1);
		end_test("register access", errs_before);

		// Random commands against the reference model
		errs_before = err_count;
		for (int n = 0; n < 200; n++) begin
			op = ops[$urandom_range(8)];
			width = widths[$urandom_range(3)];
			a = {$urandom, $urandom};
			b = {$urandom, $urandom};
			run_cmd(op, width, a, b, res);
			check_value($sformatf("result %s %s", op.name(), width.name()), res,
				ref_result(op, width, a, b));
		end
		end_test("random commands", errs_before);

		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== valu.f ====
+incdir+sim
hw/valu_pkg.sv
hw/valu_apb_regs.sv
hw/valu_lane.sv
hw/valu_result.sv
hw/valu_top.sv
sim/valu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; the result is decided from the simulation output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f valu.f --top-module valu_tb &&
./obj_dir/Vvalu_tb | tee /dev/stderr | grep -q "^sim passed$" &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }
